// File: Makefile
VERILATOR ?= verilator
TOP ?= denseLayerTb
RTL_TOP ?= denseLayer
FILELIST ?= denseLayer.f
OBJ_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS ?= --binary --timing --assert --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only -Wall --timing --timescale $(TIMESCALE)
SIM_ARGS ?= +verilator+error+limit+1000
PASS_MSG := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/clockGen.sv
`default_nettype none

module clockGen
#(
	parameter int halfPeriod = 10,
	parameter int resetCycles = 3
)
(
	output logic clk,
	output logic rstN
);

	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	initial
	begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1; // Flops still see reset on this edge
	end

endmodule

`default_nettype wire

// File: bench/denseLayerTb.sv
`default_nettype none

module denseLayerTb;

	timeunit 1ns;
	timeprecision 100ps;

	import nnPkg::*;

	localparam int directedCount = 7;
	localparam int randomCount = 48;
	localparam int resetTimeout = 20;
	localparam int drainTimeout = 8;
	localparam logic [31:0] seed = 32'h1c06_e261;

	// Columns are features x0..x3 then expected y0..y2
	localparam logic [223:0] directedTable [directedCount] = '{
		{128'h00000000_00000000_00000000_00000000, 96'h00000000_3F000000_00000000},
		{128'h40000000_40800000_3F800000_41000000, 96'h40400000_41700000_42040000},
		{128'h00000000_00000000_3F800000_00000000, 96'h00000000_3F800000_00000000},
		{128'h40000000_40000000_40000000_00000000, 96'h00000000_40600000_00000000},
		{128'hBF800000_40400000_C0000000_3F800000, 96'h40700000_40F00000_40B00000},
		{128'h41000000_00000000_00000000_3F800000, 96'h40E80000_00000000_40C00000},
		{128'h41700000_41700000_41700000_41700000, 96'h00000000_42180000_42700000}
	};

	localparam real weightTab [3][4] = '{
		'{1.0, 0.5, -2.0, 0.25},
		'{-1.0, 2.0, 0.5, 1.0},
		'{0.25, 0.25, -0.5, 4.0}
	};
	localparam real biasTab [3] = '{-1.0, 0.5, 0.0};

	logic clk;
	logic rstN;
	featureVec features;
	layerOut activations;

	layerOut expQ [$]; // One entry per vector still in flight
	int checkCount = 0;
	int errorCount = 0;
	int timeoutCount = 0;

	clockGen clockGen0 (.clk(clk), .rstN(rstN));

	denseLayer dut0 (
		.clk(clk),
		.rstN(rstN),
		.features(features),
		.activations(activations)
	);

	// Only exactly representable values reach this, so no rounding is needed
	function automatic logic [31:0] toSingle(input real value);
		logic [63:0] dbl;
		logic [31:0] word;
		dbl = $realtobits(value);
		if (dbl[62:0] == 63'd0)
			word = 32'd0;
		else
			word = {dbl[63], 8'(dbl[62:52] - 11'd896), dbl[51:29]};
		return word;
	endfunction

	function automatic layerOut referenceLayer(input real x [4]);
		layerOut result;
		logic [31:0] words [3];
		real pairLo;
		real pairHi;
		real total;
		for (int n = 0; n < 3; n++)
		begin
			pairLo = x[0] * weightTab[n][0] + x[1] * weightTab[n][1];
			pairHi = x[2] * weightTab[n][2] + x[3] * weightTab[n][3];
			total = (pairLo + pairHi) + biasTab[n];
			words[n] = (total > 0.0) ? toSingle(total) : 32'd0; // ReLU keeps zero at +0
		end
		result.y0.bits = words[0];
		result.y1.bits = words[1];
		result.y2.bits = words[2];
		return result;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("mismatch %s actual 0x%08h expected 0x%08h at %0d ns",
				name, actual, expected, $time);
		end
	endtask

	task automatic compareOutputs(input layerOut expected);
		checkValue("activations.y0", activations.y0.bits, expected.y0.bits);
		checkValue("activations.y1", activations.y1.bits, expected.y1.bits);
		checkValue("activations.y2", activations.y2.bits, expected.y2.bits);
	endtask

	// Drive on the rising edge and check the previous vector at the falling edge
	task automatic applyVector(input featureVec vec, input layerOut expected);
		@(posedge clk);
		features <= vec;
		@(negedge clk);
		if (expQ.size() > 0)
			compareOutputs(expQ.pop_front());
		expQ.push_back(expected);
	endtask

	initial
	begin
		real x [4];
		featureVec vec;
		int magnitude;
		bit negate;
		int waitCycles;

		features = '0;
		void'($urandom(seed));

		waitCycles = 0;
		while (rstN !== 1'b1 && waitCycles < resetTimeout)
		begin
			@(negedge clk);
			compareOutputs('0); // Held at +0 during and right after reset
			waitCycles++;
		end

		if (rstN !== 1'b1)
		begin
			timeoutCount++;
			$display("timeout: reset was not released within %0d cycles", resetTimeout);
		end
		else
		begin
			// Zero features are sampled on the first edge after release
			expQ.push_back(96'h00000000_3F000000_00000000);

			for (int i = 0; i < directedCount; i++)
				applyVector(directedTable[i][223:96], directedTable[i][95:0]);

			for (int r = 0; r < randomCount; r++)
			begin
				for (int i = 0; i < 4; i++)
				begin
					magnitude = int'($urandom_range(15, 0));
					negate = ($urandom_range(1, 0) != 0);
					x[i] = negate ? -real'(magnitude) : real'(magnitude);
				end
				vec.x0.bits = toSingle(x[0]);
				vec.x1.bits = toSingle(x[1]);
				vec.x2.bits = toSingle(x[2]);
				vec.x3.bits = toSingle(x[3]);
				applyVector(vec, referenceLayer(x));
			end

			waitCycles = 0;
			while (expQ.size() > 0 && waitCycles < drainTimeout)
			begin
				@(posedge clk);
				@(negedge clk);
				compareOutputs(expQ.pop_front());
				waitCycles++;
			end
			if (expQ.size() > 0)
			begin
				timeoutCount++;
				$display("timeout: %0d results never came out of the layer", expQ.size());
			end
		end

		$display("checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
			checkCount, errorCount, timeoutCount, dut0.chk0.failCount);
		if (errorCount + timeoutCount + dut0.chk0.failCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/denseLayer_chk.sv
`default_nettype none

module denseLayer_chk
(
	input wire logic clk,
	input wire logic rstN,
	input wire nnPkg::layerOut activations
);

	timeunit 1ns;
	timeprecision 100ps;

	import nnPkg::*;

	int failCount = 0;

	signClear: assert property (@(posedge clk) disable iff (!rstN)
		!(activations.y0.fields.sign || activations.y1.fields.sign
			|| activations.y2.fields.sign))
	else
	begin
		failCount++;
		$error("activation word with sign bit set");
	end

	// The first edge after release still shows the reset value
	zeroAfterReset: assert property (@(posedge clk) $rose(rstN) |-> activations == '0)
	else
	begin
		failCount++;
		$error("activations not zero on the cycle after reset release");
	end

	noInfinity: assert property (@(posedge clk) disable iff (!rstN)
		activations.y0.fields.exponent != 8'hFF && activations.y1.fields.exponent != 8'hFF
			&& activations.y2.fields.exponent != 8'hFF)
	else
	begin
		failCount++;
		$error("activation word with exponent 255");
	end

endmodule

bind denseLayer denseLayer_chk chk0 (.clk(clk), .rstN(rstN), .activations(activations));

`default_nettype wire

// File: denseLayer.f
+incdir+verilog
verilog/nnPkg.sv
verilog/floatMult.sv
verilog/floatAdder.sv
verilog/reluNode.sv
verilog/denseLayer.sv
bench/clockGen.sv
bench/denseLayer_chk.sv
bench/denseLayerTb.sv

// File: verilog/denseLayer.sv
`include "nn_params.svh"

`default_nettype none

module denseLayer
(
	input wire logic clk,
	input wire logic rstN,
	input nnPkg::featureVec features,
	output nnPkg::layerOut activations
);

	import nnPkg::*;

	// Index n holds the parameters of node n
	localparam featureVec [`NN_NODES-1:0] nodeWeights = {`NN_W2, `NN_W1, `NN_W0};
	localparam floatWord [`NN_NODES-1:0] nodeBiases = {`NN_B2, `NN_B1, `NN_B0};

	// Node n drives index NN_NODES-1-n so that y0 lands in the top word
	floatWord [`NN_NODES-1:0] nodeOut;

	for (genvar n = 0; n < `NN_NODES; n++)
	begin : genNode
		reluNode #(
			.weights(nodeWeights[n]),
			.bias(nodeBiases[n])
		) node (
			.clk(clk),
			.rstN(rstN),
			.features(features),
			.activation(nodeOut[`NN_NODES-1-n])
		);
	end

	assign activations = nodeOut;

endmodule

`default_nettype wire

// File: verilog/floatAdder.sv
`default_nettype none

module floatAdder
(
	input nnPkg::floatWord a,
	input nnPkg::floatWord b,
	output nnPkg::floatWord sum
);

	import nnPkg::*;

	floatWord bigOp;
	floatWord smallOp;
	logic sameSign;
	logic [7:0] expDiff;
	logic [23:0] sigBig;
	logic [23:0] sigSmall;
	logic [48:0] bigExt;
	logic [48:0] smallExt;
	logic [48:0] rawSum;
	logic [5:0] lzCount;
	logic [48:0] normSum;
	logic signed [9:0] expRes;

	// Position of the leading one counted from bit 48
	function automatic logic [5:0] leadZeros(input logic [48:0] value);
		logic [5:0] count;
		count = 6'd49;
		for (int i = 0; i < 49; i++)
		begin
			if (value[i])
				count = 6'(48 - i); // Highest set bit is seen last
		end
		return count;
	endfunction

	// With the sign masked off, the raw word orders by magnitude
	always_comb
	begin
		if (a.bits[30:0] >= b.bits[30:0])
		begin
			bigOp = a;
			smallOp = b;
		end
		else
		begin
			bigOp = b;
			smallOp = a;
		end
	end

	assign sameSign = a.fields.sign == b.fields.sign;
	assign expDiff = bigOp.fields.exponent - smallOp.fields.exponent;

	assign sigBig = {1'b1, bigOp.fields.mantissa};
	// A denormal small operand is taken as zero
	assign sigSmall = (smallOp.fields.exponent == 8'd0) ? 24'd0
		: {1'b1, smallOp.fields.mantissa};

	// One carry bit on top and 24 fraction bits below for the alignment
	assign bigExt = {1'b0, sigBig, 24'd0};
	assign smallExt = {1'b0, sigSmall, 24'd0} >> expDiff;

	assign rawSum = sameSign ? (bigExt + smallExt) : (bigExt - smallExt);

	assign lzCount = leadZeros(rawSum);
	assign normSum = rawSum << lzCount;

	// Leading one at bit 47 keeps the exponent of the larger operand
	assign expRes = $signed({2'b00, bigOp.fields.exponent})
		+ 10'sd1
		- $signed({4'b0000, lzCount});

	always_comb
	begin
		sum.bits = 32'd0;
		if (bigOp.fields.exponent == 8'd0)
		begin
			sum.bits = 32'd0; // Both operands are zero or denormal
		end
		else if (rawSum == 49'd0)
		begin
			sum.bits = 32'd0; // Exact cancellation gives +0
		end
		else if (expRes <= 10'sd0)
		begin
			sum.bits = 32'd0;
		end
		else if (expRes >= 10'sd255)
		begin
			sum.fields.sign = bigOp.fields.sign;
			sum.fields.exponent = 8'hFF;
			sum.fields.mantissa = 23'd0;
		end
		else
		begin
			sum.fields.sign = bigOp.fields.sign;
			sum.fields.exponent = expRes[7:0];
			sum.fields.mantissa = normSum[47:25]; // Bits below are truncated
		end
	end

endmodule

`default_nettype wire

// File: verilog/floatMult.sv
`default_nettype none

module floatMult
(
	input nnPkg::floatWord a,
	input nnPkg::floatWord b,
	output nnPkg::floatWord product
);

	import nnPkg::*;

	logic resSign;
	logic [23:0] sigA;
	logic [23:0] sigB;
	logic [47:0] sigProd;
	logic signed [9:0] expSum;
	logic signed [9:0] expNorm;
	logic [22:0] mantNorm;
	logic zeroIn;

	// Operands with a zero exponent are zero or denormal and both count as zero
	assign zeroIn = (a.fields.exponent == 8'd0) || (b.fields.exponent == 8'd0);

	assign resSign = a.fields.sign ^ b.fields.sign;
	assign sigA = {1'b1, a.fields.mantissa};
	assign sigB = {1'b1, b.fields.mantissa};
	assign sigProd = sigA * sigB; // Binary point sits between bits 46 and 45

	// Remove one bias so the sum is again biased by 127
	assign expSum = $signed({2'b00, a.fields.exponent})
		+ $signed({2'b00, b.fields.exponent})
		- 10'sd127;

	always_comb
	begin
		if (sigProd[47])
		begin
			// Product in [2,4) needs one step right
			mantNorm = sigProd[46:24];
			expNorm = expSum + 10'sd1;
		end
		else
		begin
			mantNorm = sigProd[45:23];
			expNorm = expSum;
		end
	end

	always_comb
	begin
		product.bits = 32'd0;
		if (zeroIn)
		begin
			product.bits = 32'd0;
		end
		else if (expNorm <= 10'sd0)
		begin
			product.bits = 32'd0; // Underflow flushes to +0
		end
		else if (expNorm >= 10'sd255)
		begin
			product.fields.sign = resSign;
			product.fields.exponent = 8'hFF;
			product.fields.mantissa = 23'd0;
		end
		else
		begin
			product.fields.sign = resSign;
			product.fields.exponent = expNorm[7:0];
			product.fields.mantissa = mantNorm; // Low product bits are dropped
		end
	end

endmodule

`default_nettype wire

// File: verilog/nnPkg.sv
`default_nettype none

package nnPkg;

	// IEEE-754 single-precision field layout
	typedef struct packed
	{
		logic sign;
		logic [7:0] exponent; // Biased by 127
		logic [22:0] mantissa; // Hidden one is not stored
	} floatFields;

	// Raw word and field split of the same 32 bits
	typedef union packed
	{
		logic [31:0] bits;
		floatFields fields;
	} floatWord;

	// Layer input with x0 in the most significant word
	typedef struct packed
	{
		floatWord x0;
		floatWord x1;
		floatWord x2;
		floatWord x3;
	} featureVec;

	// One activation per neuron with y0 in the most significant word
	typedef struct packed
	{
		floatWord y0;
		floatWord y1;
		floatWord y2;
	} layerOut;

endpackage

`default_nettype wire

// File: verilog/nn_params.svh
`ifndef NN_PARAMS_SVH
`define NN_PARAMS_SVH

`default_nettype none

// Layer shape
`define NN_INPUTS 4
`define NN_NODES 3

// Weight vectors in word order x0 x1 x2 x3
// Node 0 is 1.0 0.5 -2.0 0.25
`define NN_W0 128'h3F800000_3F000000_C0000000_3E800000
// Node 1 is -1.0 2.0 0.5 1.0
`define NN_W1 128'hBF800000_40000000_3F000000_3F800000
// Node 2 is 0.25 0.25 -0.5 4.0
`define NN_W2 128'h3E800000_3E800000_BF000000_40800000

// Biases -1.0 0.5 0.0
`define NN_B0 32'hBF800000
`define NN_B1 32'h3F000000
`define NN_B2 32'h00000000

`default_nettype wire

`endif

// File: verilog/reluNode.sv
`include "nn_params.svh"

`default_nettype none

module reluNode
#(
	parameter nnPkg::featureVec weights = '0,
	parameter nnPkg::floatWord bias = '0
)
(
	input wire logic clk,
	input wire logic rstN,
	input nnPkg::featureVec features,
	output nnPkg::floatWord activation
);

	import nnPkg::*;

	// Word i of the vector lives at index NN_INPUTS-1-i
	localparam floatWord [`NN_INPUTS-1:0] weightWords = weights;

	floatWord [`NN_INPUTS-1:0] featWords;
	floatWord products [`NN_INPUTS];
	floatWord pairLo;
	floatWord pairHi;
	floatWord treeSum;
	floatWord biased;

	assign featWords = features;

	for (genvar i = 0; i < `NN_INPUTS; i++)
	begin : genMult
		floatMult mult (
			.a(featWords[`NN_INPUTS-1-i]),
			.b(weightWords[`NN_INPUTS-1-i]),
			.product(products[i])
		);
	end

	// Fixed order ((p0+p1)+(p2+p3))+bias
	floatAdder addLo (.a(products[0]), .b(products[1]), .sum(pairLo));
	floatAdder addHi (.a(products[2]), .b(products[3]), .sum(pairHi));
	floatAdder addTree (.a(pairLo), .b(pairHi), .sum(treeSum));
	floatAdder addBias (.a(treeSum), .b(bias), .sum(biased));

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			activation <= '0;
		end
		else if (biased.fields.sign)
		begin
			activation <= '0; // Negative results clamp to +0
		end
		else
		begin
			activation <= biased;
		end
	end

endmodule

`default_nettype wire
